// File: flist.f
pad_pkg.sv
pad_scan_timer.sv
pad_deserializer.sv
pad_read_port.sv
pad_reader_top.sv
pad_model.sv
tb_pad_reader.sv

// File: pad_deserializer.sv
`default_nettype none

module pad_deserializer
    import pad_pkg::*;
(
    input  wire         clk,
    input  wire         aresetn,
    input  wire         data,
    input  wire         sample,
    input  wire         frame_done,
    output pad_report_u report
);

    logic [PAD_BITS-1:0]  shreg;
    logic [BIT_CNT_W-1:0] bit_cnt;

    always_ff @(posedge clk) begin
        if (sample && bit_cnt < BIT_CNT_W'(PAD_BITS)) begin
            shreg <= {~data, shreg[PAD_BITS-1:1]};  // lsb first, active low
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            bit_cnt <= '0;
        end else if (frame_done) begin
            bit_cnt <= '0;
        end else if (sample && bit_cnt < BIT_CNT_W'(PAD_BITS)) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            report.raw <= '0;
        end else if (frame_done) begin
            report.f.present  <= shreg[15:12] == 4'b0000;  // pad id nibble
            report.f.reserved <= 3'b000;
            report.f.buttons  <= shreg[11:0];
        end
    end

    // every frame must deliver a full word
    assert property (@(posedge clk) disable iff (!aresetn)
        frame_done |-> bit_cnt == BIT_CNT_W'(PAD_BITS))
        else $error("frame_done after %0d samples", bit_cnt);

endmodule

`default_nettype wire

// File: pad_model.sv
`default_nettype none

module pad_model (
    input  wire        latch,
    input  wire        pad_clk,
    input  wire [15:0] pattern,
    input  wire        connected,
    output logic       data
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] shreg;

    initial begin
        shreg = 16'hffff;  // released buttons read high
    end

    // reload on the rising edge of latch
    always @(posedge latch or posedge pad_clk) begin
        if (latch) begin
            shreg <= ~pattern;  // pressed buttons pull the line low
        end else begin
            shreg <= {1'b1, shreg[15:1]};  // shift in ones behind the last bit
        end
    end

    // an empty port has no pull-up on the data line
    assign data = connected ? shreg[0] : 1'b0;

endmodule

`default_nettype wire

// File: pad_pkg.sv
`default_nettype none

package pad_pkg;

    localparam int HALF_BIT_CYCLES = 4;  // clk cycles per pad clock half
    localparam int LATCH_HALVES    = 2;
    localparam int GAP_HALVES      = 8;
    localparam int PAD_BITS        = 16;

    localparam int BITS_END     = LATCH_HALVES + 2 * PAD_BITS;  // first gap half
    localparam int FRAME_HALVES = BITS_END + GAP_HALVES;
    localparam int FRAME_CYCLES = FRAME_HALVES * HALF_BIT_CYCLES;

    localparam int CNT_W     = $clog2(HALF_BIT_CYCLES);
    localparam int IDX_W     = $clog2(FRAME_HALVES);
    localparam int BIT_CNT_W = $clog2(PAD_BITS + 1);

    localparam logic [31:0] ADDR_BUTTONS = 32'h0000_0000;
    localparam logic [31:0] ADDR_FRAMES  = 32'h0000_0004;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic        present;   // genuine pad signature seen
        logic [2:0]  reserved;
        logic [11:0] buttons;
    } pad_fields_t;

    typedef union packed {
        logic [15:0] raw;
        pad_fields_t f;
    } pad_report_u;

endpackage

`default_nettype wire

// File: pad_read_port.sv
`default_nettype none

module pad_read_port
    import pad_pkg::*;
(
    input  wire         clk,
    input  wire         aresetn,
    input  wire  [31:0] araddr,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  wire         rready,
    input  wire pad_report_u report0,
    input  wire pad_report_u report1,
    input  wire         frame_done
);

    logic [31:0] frame_cnt;
    logic [31:0] rd_word;
    logic [1:0]  rd_resp;
    logic        ar_fire;

    assign arready = !rvalid;  // one read in flight
    assign ar_fire = arvalid && arready;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            frame_cnt <= '0;
        end else if (frame_done) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            ADDR_BUTTONS: rd_word = {report1.raw, report0.raw};
            ADDR_FRAMES:  rd_word = frame_cnt;
            default:      rd_resp = RESP_SLVERR;  // unmapped address reads zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    // R channel held under back-pressure
    assert property (@(posedge clk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("R channel changed before rready");

endmodule

`default_nettype wire

// File: pad_reader_top.sv
`default_nettype none

module pad_reader_top
    import pad_pkg::*;
(
    input  wire         clk,
    input  wire         aresetn,
    input  wire         pad0_data,
    output logic        pad0_latch,
    output logic        pad0_clk,
    input  wire         pad1_data,
    output logic        pad1_latch,
    output logic        pad1_clk,
    input  wire  [31:0] araddr,
    input  wire         arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  wire         rready
);

    logic        pad_latch;
    logic        pad_clk;
    logic        sample;
    logic        frame_done;
    pad_report_u report0;
    pad_report_u report1;

    // both pads share one latch and clock
    assign pad0_latch = pad_latch;
    assign pad1_latch = pad_latch;
    assign pad0_clk   = pad_clk;
    assign pad1_clk   = pad_clk;

    pad_scan_timer pad_scan_timer_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .pad_latch  (pad_latch),
        .pad_clk    (pad_clk),
        .sample     (sample),
        .frame_done (frame_done)
    );

    pad_deserializer pad_deserializer_0 (
        .clk        (clk),
        .aresetn    (aresetn),
        .data       (pad0_data),
        .sample     (sample),
        .frame_done (frame_done),
        .report     (report0)
    );

    pad_deserializer pad_deserializer_1 (
        .clk        (clk),
        .aresetn    (aresetn),
        .data       (pad1_data),
        .sample     (sample),
        .frame_done (frame_done),
        .report     (report1)
    );

    pad_read_port pad_read_port_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .report0    (report0),
        .report1    (report1),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

// File: pad_scan_timer.sv
`default_nettype none

module pad_scan_timer
    import pad_pkg::*;
(
    input  wire  clk,
    input  wire  aresetn,
    output logic pad_latch,
    output logic pad_clk,
    output logic sample,
    output logic frame_done
);

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_nxt;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] idx_nxt;
    logic [IDX_W-1:0] rel_idx;
    logic             in_latch;
    logic             in_bits;
    logic             low_half;
    logic             last_cyc;

    always_comb begin
        cnt_nxt = cnt + 1'b1;
        idx_nxt = idx;
        if (cnt == CNT_W'(HALF_BIT_CYCLES - 1)) begin
            cnt_nxt = '0;
            if (idx == IDX_W'(FRAME_HALVES - 1)) begin
                idx_nxt = '0;  // next frame
            end else begin
                idx_nxt = idx + 1'b1;
            end
        end
    end

    // decode the coming cycle so the outputs leave a flop
    always_comb begin
        rel_idx  = idx_nxt - IDX_W'(LATCH_HALVES);
        in_latch = idx_nxt < IDX_W'(LATCH_HALVES);
        in_bits  = (idx_nxt >= IDX_W'(LATCH_HALVES)) && (idx_nxt < IDX_W'(BITS_END));
        low_half = in_bits && !rel_idx[0];  // first half of each bit slot
        last_cyc = cnt_nxt == CNT_W'(HALF_BIT_CYCLES - 1);
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            cnt        <= '0;
            idx        <= '0;
            pad_latch  <= 1'b1;
            pad_clk    <= 1'b1;
            sample     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            cnt        <= cnt_nxt;
            idx        <= idx_nxt;
            pad_latch  <= in_latch;
            pad_clk    <= !low_half;  // idles high
            sample     <= low_half && last_cyc;
            frame_done <= last_cyc && (idx_nxt == IDX_W'(BITS_END - 1));
        end
    end

    // pads are still loading while latch is up
    assert property (@(posedge clk) disable iff (!aresetn)
        sample |-> !pad_latch)
        else $error("sample strobe during latch");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the pad reader testbench with Verilator and run it.
# Pass or fail is taken from the log.

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Simulation FAILED"

verilator --binary --timing --assert \
    --top-module tb_pad_reader \
    -f flist.f \
    --Mdir obj_dir \
    -o sim_pad_reader
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_pad_reader > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    echo "testbench reported failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

exit 0

// File: tb_pad_reader.sv
`default_nettype none

module tb_pad_reader
    import pad_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 20;
    localparam int DRIVE_DLY        = 2;
    localparam int SEED             = 1683;
    localparam int RANDOM_PAIRS     = 20;
    localparam int DISCONNECT_PAIRS = 2;
    localparam int FRAME_GAP        = 3;
    localparam int STALL_CYCLES     = 6;
    localparam int READ_TIMEOUT     = 50;
    localparam int NUM_TESTS   = 1 + RANDOM_PAIRS + DISCONNECT_PAIRS + 1 + FRAME_GAP + 2;
    localparam int WATCHDOG_NS = NUM_TESTS * 3 * FRAME_CYCLES * CLK_PERIOD + 5000;

    logic        clk;
    logic        aresetn;
    logic        pad0_data;
    logic        pad0_latch;
    logic        pad0_clk;
    logic        pad1_data;
    logic        pad1_latch;
    logic        pad1_clk;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    logic [15:0] pat0;
    logic [15:0] pat1;
    logic        conn0;
    logic        conn1;
    logic [31:0] rng;
    int          cycle_cnt;

    event pattern_set;
    event compare_done;

    pad_reader_top pad_reader_top_i (
        .clk        (clk),
        .aresetn    (aresetn),
        .pad0_data  (pad0_data),
        .pad0_latch (pad0_latch),
        .pad0_clk   (pad0_clk),
        .pad1_data  (pad1_data),
        .pad1_latch (pad1_latch),
        .pad1_clk   (pad1_clk),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready)
    );

    pad_model pad_model_0 (
        .latch     (pad0_latch),
        .pad_clk   (pad0_clk),
        .pattern   (pat0),
        .connected (conn0),
        .data      (pad0_data)
    );

    pad_model pad_model_1 (
        .latch     (pad1_latch),
        .pad_clk   (pad1_clk),
        .pattern   (pat1),
        .connected (conn1),
        .data      (pad1_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // button register as software should see it
    function automatic logic [31:0] expected_buttons(input logic [15:0] p0, input logic [15:0] p1,
                                                     input logic c0, input logic c1);
        logic [15:0] bits0;
        logic [15:0] bits1;
        pad_report_u r0;
        pad_report_u r1;
        bits0 = c0 ? p0 : 16'hffff;  // floating low line reads as all pressed
        bits1 = c1 ? p1 : 16'hffff;
        r0.f.present  = bits0[15:12] == 4'b0000;
        r0.f.reserved = 3'b000;
        r0.f.buttons  = bits0[11:0];
        r1.f.present  = bits1[15:12] == 4'b0000;
        r1.f.reserved = 3'b000;
        r1.f.buttons  = bits1[11:0];
        return {r1.raw, r0.raw};
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("mismatch at %0d ns: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic axi_read(input logic [31:0] addr, input int stall,
                            output logic [31:0] data, output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk);
        #DRIVE_DLY;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            waited++;
            if (waited > READ_TIMEOUT) begin
                stop_with_failure($sformatf("read of %h never saw arready", addr));
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        @(posedge clk);  // AR transfer
        #DRIVE_DLY;
        arvalid = 1'b0;
        araddr  = '0;
        check_value("rvalid", 32'(rvalid), 32'd1);
        data = rdata;
        resp = rresp;
        repeat (stall) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_value("rvalid", 32'(rvalid), 32'd1);
            check_value("rdata", rdata, data);
            check_value("rresp", 32'(rresp), 32'(resp));
            check_value("arready", 32'(arready), 32'd0);
        end
        rready = 1'b1;
        @(posedge clk);  // R transfer
        #DRIVE_DLY;
        rready = 1'b0;
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("arready", 32'(arready), 32'd1);
    endtask

    task automatic apply_patterns(input logic [15:0] p0, input logic [15:0] p1,
                                  input logic c0, input logic c1);
        @(posedge clk);
        #DRIVE_DLY;
        pat0  = p0;
        pat1  = p1;
        conn0 = c0;
        conn1 = c1;
        -> pattern_set;
        @(compare_done);
    endtask

    initial begin : compare_proc
        logic [31:0] got;
        logic [1:0]  resp;
        forever begin
            @(pattern_set);
            repeat (2 * FRAME_CYCLES) @(posedge clk);  // let any frame in flight pass
            axi_read(ADDR_BUTTONS, 0, got, resp);
            check_value("rdata buttons", got, expected_buttons(pat0, pat1, conn0, conn1));
            check_value("rresp buttons", 32'(resp), 32'(RESP_OKAY));
            -> compare_done;
        end
    end

    initial begin : watchdog
        #WATCHDOG_NS;
        stop_with_failure("watchdog expired before all tests finished");
    end

    initial begin : stimulus
        logic [31:0] rd;
        logic [1:0]  rs;
        logic [31:0] frames_a;
        logic [31:0] frames_b;
        logic [15:0] p0;
        logic [15:0] p1;
        int          start_cyc;
        int          i;
        clk       = 1'b0;
        aresetn   = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        pat0      = '0;
        pat1      = '0;
        conn0     = 1'b1;
        conn1     = 1'b1;
        cycle_cnt = 0;
        rng       = 32'(SEED);
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        aresetn = 1'b1;

        check_value("pad0_latch", 32'(pad0_latch), 32'd1);
        check_value("pad1_latch", 32'(pad1_latch), 32'd1);
        check_value("pad0_clk", 32'(pad0_clk), 32'd1);
        check_value("pad1_clk", 32'(pad1_clk), 32'd1);
        check_value("rvalid", 32'(rvalid), 32'd0);
        check_value("arready", 32'(arready), 32'd1);
        axi_read(ADDR_BUTTONS, 0, rd, rs);  // well before the first frame_done
        check_value("rdata buttons", rd, 32'd0);
        axi_read(ADDR_FRAMES, 0, rd, rs);
        check_value("rdata frames", rd, 32'd0);
        check_value("rresp frames", 32'(rs), 32'(RESP_OKAY));

        for (i = 0; i < RANDOM_PAIRS; i++) begin
            rng = next_random(rng);
            p0  = rng[15:0] & 16'h0fff;  // keep the pad signature
            rng = next_random(rng);
            p1  = rng[15:0] & 16'h0fff;
            apply_patterns(p0, p1, 1'b1, 1'b1);
        end

        for (i = 0; i < DISCONNECT_PAIRS; i++) begin
            rng = next_random(rng);
            p0  = rng[15:0] & 16'h0fff;
            rng = next_random(rng);
            p1  = rng[15:0] & 16'h0fff;
            apply_patterns(p0, p1, 1'b1, 1'b0);
        end
        rng = next_random(rng);
        apply_patterns(rng[15:0] & 16'h0fff, rng[31:16] & 16'h0fff, 1'b1, 1'b1);

        // same phase for both reads so exactly FRAME_GAP frames lie in between
        @(posedge clk);
        #DRIVE_DLY;
        start_cyc = cycle_cnt;
        axi_read(ADDR_FRAMES, 0, frames_a, rs);
        while (cycle_cnt != start_cyc + FRAME_GAP * FRAME_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        axi_read(ADDR_FRAMES, 0, frames_b, rs);
        check_value("frame count delta", frames_b - frames_a, 32'(FRAME_GAP));

        axi_read(32'h0000_0008, 0, rd, rs);
        check_value("rdata unmapped", rd, 32'd0);
        check_value("rresp unmapped", 32'(rs), 32'(RESP_SLVERR));

        axi_read(ADDR_FRAMES, STALL_CYCLES, rd, rs);
        check_value("rresp stalled", 32'(rs), 32'(RESP_OKAY));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
